// File: verilog/hd44780_timing_pkg.sv
// package with HD44780 enable-cycle tick counts, post-nybble delays in microseconds, counter widths

package hd44780_timing_pkg;

    // ****************************************
    // enable cycle, in clock ticks
    // ****************************************

    // address setup, RS and data settle before E goes up
    localparam int TICKS_TAS = 3;

    // E high time, long enough for the 450 ns minimum at 48 MHz
    localparam int TICKS_PWEH = 22;

    // rise of E to the end of the whole enable cycle, about 1 us at 48 MHz
    localparam int TICKS_TCYCE = 48;

    // holds TICKS_TAS + TICKS_TCYCE
    localparam int CYCLE_COUNT_W = 6;

    // ****************************************
    // execution delays, in microseconds
    // ****************************************

    // power-on wait before the first function set
    localparam int US_100MS = 100000;
    // after the first 0x3 nybble, which is much slower than the rest
    localparam int US_4P1MS = 4100;
    // clear display and return home touch all of DDRAM
    localparam int US_3MS = 3000;
    // later 0x3 nybbles and the switch to 4-bit mode
    localparam int US_100US = 100;
    // ordinary instructions and data writes
    localparam int US_53US = 53;

    // enough for the 100 ms wait
    localparam int DELAY_COUNT_W = 17;

endpackage

// File: verilog/hd44780_cmd_pkg.sv
// package with nybble item layout, delay codes, power-on init table and buffer depth

package hd44780_cmd_pkg;

    // ****************************************
    // delay codes carried in each item
    // ****************************************

    localparam int DELAY_CODE_W = 3;

    localparam logic [DELAY_CODE_W-1:0] DLY_NONE = 3'd0;
    localparam logic [DELAY_CODE_W-1:0] DLY_53US = 3'd1;
    localparam logic [DELAY_CODE_W-1:0] DLY_100US = 3'd2;
    localparam logic [DELAY_CODE_W-1:0] DLY_4P1MS = 3'd3;
    localparam logic [DELAY_CODE_W-1:0] DLY_3MS = 3'd4;
    localparam logic [DELAY_CODE_W-1:0] DLY_100MS = 3'd5;

    // item is {delay code, pulse flag, rs, nybble}
    // a clear pulse flag makes the item a pure wait with no E pulse
    localparam int ITEM_W = 9;
    localparam int ITEM_DLY_MSB = 8;
    localparam int ITEM_DLY_LSB = 6;
    localparam int ITEM_PULSE = 5;
    localparam int ITEM_RS = 4;

    // ****************************************
    // power-on init in 4-bit mode
    // ****************************************

    localparam int INIT_LEN = 15;
    localparam int INIT_IDX_W = $clog2(INIT_LEN);

    // first the 100 ms wait, then the 0x3 0x3 0x3 0x2 reset dance
    // followed by function set, display off, clear, entry mode and display on
    localparam logic [ITEM_W-1:0] INIT_TABLE [INIT_LEN] = '{
        {DLY_100MS, 1'b0, 1'b0, 4'h0},
        {DLY_4P1MS, 1'b1, 1'b0, 4'h3},
        {DLY_100US, 1'b1, 1'b0, 4'h3},
        {DLY_100US, 1'b1, 1'b0, 4'h3},
        {DLY_100US, 1'b1, 1'b0, 4'h2},
        {DLY_NONE, 1'b1, 1'b0, 4'h2},
        {DLY_53US, 1'b1, 1'b0, 4'h8},
        {DLY_NONE, 1'b1, 1'b0, 4'h0},
        {DLY_53US, 1'b1, 1'b0, 4'h8},
        {DLY_NONE, 1'b1, 1'b0, 4'h0},
        {DLY_3MS, 1'b1, 1'b0, 4'h1},
        {DLY_NONE, 1'b1, 1'b0, 4'h0},
        {DLY_53US, 1'b1, 1'b0, 4'h6},
        {DLY_NONE, 1'b1, 1'b0, 4'h0},
        {DLY_53US, 1'b1, 1'b0, 4'hc}
    };

    // item buffer between sequencer and sender
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

endpackage

// File: verilog/hd44780_sequencer.sv
// HD44780 sequencer: init table walk, host byte split into nybble items, host busy flag
`timescale 1ns/10ps

module hd44780_sequencer
    import hd44780_cmd_pkg::*;
(
    input  logic              CLK_I,
    input  logic              RST_I,
    input  logic              i_stb,
    input  logic              i_rs,
    input  logic [7:0]        i_byte,
    input  logic              i_fifo_full,
    input  logic              i_fifo_empty,
    input  logic              i_sender_busy,
    output logic              o_busy,
    output logic              o_push,
    output logic [ITEM_W-1:0] o_item
);

    // init walks the table, high and low push the two halves of a host byte,
    // drain waits for the buffer and the sender to finish before going idle
    typedef enum logic [2:0] {S_INIT, S_IDLE, S_HIGH, S_LOW, S_DRAIN} state_t;

    state_t                  state;
    state_t                  state_d;
    logic [INIT_IDX_W-1:0]   init_idx;
    logic                    busy_q;
    logic [7:0]              byte_q;
    logic                    rs_q;
    logic [DELAY_CODE_W-1:0] low_dly;
    logic                    accept;
    logic                    pending;

    // a strobe only counts in idle with busy low and anything else is dropped
    assign accept = i_stb && (state == S_IDLE) && !busy_q;

    // these states hold an item that still has to reach the buffer
    assign pending = (state == S_INIT) || (state == S_HIGH) || (state == S_LOW);
    assign o_push = pending && !i_fifo_full;

    // clear display and return home need the long wait and every other byte 53 us
    assign low_dly = (!rs_q && (byte_q == 8'h01 || byte_q == 8'h02)) ? DLY_3MS : DLY_53US;

    always_comb begin
        state_d = state;
        case (state)
            S_INIT: begin
                if (!i_fifo_full && init_idx == INIT_IDX_W'(INIT_LEN - 1)) begin
                    state_d = S_DRAIN;
                end
            end
            S_IDLE: begin
                if (accept) begin
                    state_d = S_HIGH;
                end
            end
            S_HIGH: begin
                if (!i_fifo_full) begin
                    state_d = S_LOW;
                end
            end
            S_LOW: begin
                if (!i_fifo_full) begin
                    state_d = S_DRAIN;
                end
            end
            S_DRAIN: begin
                // the sender raises busy the cycle after its pop, so empty and idle
                // together really mean every pushed nybble has gone out
                if (i_fifo_empty && !i_sender_busy) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // the item mux stays put while the buffer is full
    always_comb begin
        case (state)
            S_INIT: o_item = INIT_TABLE[init_idx];
            S_HIGH: o_item = {DLY_NONE, 1'b1, rs_q, byte_q[7:4]};
            S_LOW: o_item = {low_dly, 1'b1, rs_q, byte_q[3:0]};
            default: o_item = '0;
        endcase
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state <= S_INIT;
            init_idx <= '0;
            busy_q <= 1'b0;
        end else begin
            state <= state_d;
            // busy follows the next state, so it is up the cycle after an accept
            busy_q <= (state_d != S_IDLE);
            if (state == S_INIT && !i_fifo_full) begin
                init_idx <= init_idx + 1'b1;
            end
        end
    end

    // host byte and RS captured on accept
    always_ff @(posedge CLK_I) begin
        if (accept) begin
            byte_q <= i_byte;
            rs_q <= i_rs;
        end
    end

    assign o_busy = busy_q;

    // an item that waits on a full buffer must not change before it is pushed
    a_hold_while_full: assert property (@(posedge CLK_I) disable iff (RST_I)
        (pending && i_fifo_full) |=> $stable(o_item));

    // with busy low the whole pipe behind us has gone quiet
    a_idle_means_drained: assert property (@(posedge CLK_I) disable iff (RST_I)
        !o_busy |-> (i_fifo_empty && !i_sender_busy));

endmodule

// File: verilog/hd44780_nybble_fifo.sv
// HD44780 nybble item FIFO: register array with read and write pointers and occupancy count
`timescale 1ns/10ps

module hd44780_nybble_fifo
    import hd44780_cmd_pkg::*;
(
    input  logic              CLK_I,
    input  logic              RST_I,
    input  logic              i_push,
    input  logic [ITEM_W-1:0] i_item,
    input  logic              i_pop,
    output logic [ITEM_W-1:0] o_item,
    output logic              o_full,
    output logic              o_empty
);

    logic [ITEM_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    // storage, written only on push
    always_ff @(posedge CLK_I) begin
        if (i_push) begin
            mem[wr_ptr] <= i_item;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head item is valid whenever empty is low
    assign o_item = mem[rd_ptr];
    assign o_full = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign o_empty = (count == '0);

    // the sequencer has to respect full
    a_push_full: assert property (@(posedge CLK_I) disable iff (RST_I) i_push |-> !o_full);

    // the sender must only pop a valid head
    a_pop_empty: assert property (@(posedge CLK_I) disable iff (RST_I) i_pop |-> !o_empty);

endmodule

// File: verilog/hd44780_nybble_sender.sv
// HD44780 nybble sender: RS, data and E pin timing plus the post-nybble execution delay
`timescale 1ns/10ps

module hd44780_nybble_sender
    import hd44780_timing_pkg::*;
    import hd44780_cmd_pkg::*;
#(
    parameter int TICKS_PER_US = 48
) (
    input  logic              CLK_I,
    input  logic              RST_I,
    input  logic [ITEM_W-1:0] i_item,
    input  logic              i_empty,
    output logic              o_pop,
    output logic              o_busy,
    output logic [3:0]        o_lcd_data,
    output logic              o_rs,
    output logic              o_e
);

    // prescaler width, one bit minimum when a tick is already a microsecond
    localparam int PRE_W = (TICKS_PER_US > 1) ? $clog2(TICKS_PER_US) : 1;

    typedef enum logic [1:0] {S_IDLE, S_CYCLE, S_DELAY} state_t;

    state_t                   state;
    logic [CYCLE_COUNT_W-1:0] cyc_cnt;
    logic [DELAY_COUNT_W-1:0] dly_cnt;
    logic [PRE_W-1:0]         pre_cnt;
    logic                     e_q;
    logic                     rs_q;
    logic [3:0]               data_q;
    logic                     pulse_q;
    logic [DELAY_CODE_W-1:0]  code_q;

    // microseconds of execution time behind each delay code
    function automatic logic [DELAY_COUNT_W-1:0] delay_us(input logic [DELAY_CODE_W-1:0] code);
        case (code)
            DLY_53US: delay_us = DELAY_COUNT_W'(US_53US);
            DLY_100US: delay_us = DELAY_COUNT_W'(US_100US);
            DLY_4P1MS: delay_us = DELAY_COUNT_W'(US_4P1MS);
            DLY_3MS: delay_us = DELAY_COUNT_W'(US_3MS);
            DLY_100MS: delay_us = DELAY_COUNT_W'(US_100MS);
            default: delay_us = '0;
        endcase
    endfunction

    // one-cycle pop whenever we are idle and the head is valid
    assign o_pop = (state == S_IDLE) && !i_empty;
    assign o_busy = (state != S_IDLE);

    // ****************************************
    // enable cycle and delay countdown
    // ****************************************

    // cyc_cnt is TICKS_TAS + TICKS_TCYCE at t0 and steps down by one per tick
    // E is set one count early so the registered pin rises exactly at t0 + TICKS_TAS
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state <= S_IDLE;
            cyc_cnt <= '0;
            dly_cnt <= '0;
            pre_cnt <= '0;
            e_q <= 1'b0;
            rs_q <= 1'b0;
            data_q <= 4'h0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (o_pop) begin
                        rs_q <= i_item[ITEM_RS];
                        data_q <= i_item[3:0];
                        cyc_cnt <= CYCLE_COUNT_W'(TICKS_TAS + TICKS_TCYCE);
                        state <= S_CYCLE;
                    end
                end
                S_CYCLE: begin
                    cyc_cnt <= cyc_cnt - 1'b1;
                    // wait-only items run the same count with E left low
                    if (cyc_cnt == CYCLE_COUNT_W'(TICKS_TCYCE + 1) && pulse_q) begin
                        e_q <= 1'b1;
                    end
                    if (cyc_cnt == CYCLE_COUNT_W'(TICKS_TCYCE - TICKS_PWEH + 1)) begin
                        e_q <= 1'b0;
                    end
                    // last tick of the enable cycle, hand over to the delay
                    if (cyc_cnt == CYCLE_COUNT_W'(1)) begin
                        dly_cnt <= delay_us(code_q);
                        pre_cnt <= PRE_W'(TICKS_PER_US - 1);
                        state <= (code_q == DLY_NONE) ? S_IDLE : S_DELAY;
                    end
                end
                S_DELAY: begin
                    // each microsecond is TICKS_PER_US ticks of the prescaler
                    if (pre_cnt == '0) begin
                        pre_cnt <= PRE_W'(TICKS_PER_US - 1);
                        dly_cnt <= dly_cnt - 1'b1;
                        if (dly_cnt == DELAY_COUNT_W'(1)) begin
                            state <= S_IDLE;
                        end
                    end else begin
                        pre_cnt <= pre_cnt - 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // pulse flag and delay code of the item in flight
    always_ff @(posedge CLK_I) begin
        if (o_pop) begin
            pulse_q <= i_item[ITEM_PULSE];
            code_q <= i_item[ITEM_DLY_MSB:ITEM_DLY_LSB];
        end
    end

    assign o_lcd_data = data_q;
    assign o_rs = rs_q;
    assign o_e = e_q;

    // the LCD latches on the fall of E, so the bus must hold for the whole pulse
    a_bus_stable: assert property (@(posedge CLK_I) disable iff (RST_I)
        o_e |-> ($stable(o_lcd_data) && $stable(o_rs)));

    // every pulse is exactly TICKS_PWEH ticks wide
    a_pulse_width: assert property (@(posedge CLK_I) disable iff (RST_I)
        $rose(o_e) |-> o_e [*TICKS_PWEH] ##1 !o_e);

endmodule

// File: verilog/hd44780_controller.sv
// HD44780 controller top: sequencer, nybble FIFO and nybble sender
`timescale 1ns/10ps

module hd44780_controller
    import hd44780_cmd_pkg::*;
#(
    parameter int TICKS_PER_US = 48
) (
    input  logic       CLK_I,
    input  logic       RST_I,
    input  logic       i_stb,
    input  logic       i_rs,
    input  logic [7:0] i_byte,
    output logic       o_busy,
    output logic       o_rs,
    output logic [3:0] o_lcd_data,
    output logic       o_e
);

    // sequencer to FIFO
    logic              seq_push;
    logic [ITEM_W-1:0] seq_item;
    logic              fifo_full;

    // FIFO to sender, plus the status the sequencer needs to drop busy
    logic [ITEM_W-1:0] head_item;
    logic              fifo_empty;
    logic              sender_pop;
    logic              sender_busy;

    hd44780_sequencer seq0 (
        .CLK_I         (CLK_I),
        .RST_I         (RST_I),
        .i_stb         (i_stb),
        .i_rs          (i_rs),
        .i_byte        (i_byte),
        .i_fifo_full   (fifo_full),
        .i_fifo_empty  (fifo_empty),
        .i_sender_busy (sender_busy),
        .o_busy        (o_busy),
        .o_push        (seq_push),
        .o_item        (seq_item)
    );

    hd44780_nybble_fifo fifo0 (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .i_push  (seq_push),
        .i_item  (seq_item),
        .i_pop   (sender_pop),
        .o_item  (head_item),
        .o_full  (fifo_full),
        .o_empty (fifo_empty)
    );

    hd44780_nybble_sender #(
        .TICKS_PER_US (TICKS_PER_US)
    ) sender0 (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .i_item     (head_item),
        .i_empty    (fifo_empty),
        .o_pop      (sender_pop),
        .o_busy     (sender_busy),
        .o_lcd_data (o_lcd_data),
        .o_rs       (o_rs),
        .o_e        (o_e)
    );

endmodule

// File: sim/hd44780_checker.sv
// HD44780 checker: LCD pin monitor, init nybble compare, byte rebuild, pulse and gap timing
`timescale 1ns/10ps

module hd44780_checker
    import hd44780_timing_pkg::*;
#(
    parameter int TICKS_PER_US = 1
) (
    input  logic       CLK_I,
    input  logic       RST_I,
    input  logic       i_e,
    input  logic       i_rs,
    input  logic [3:0] i_lcd_data,
    input  logic       i_busy,
    input  logic       i_stb,
    input  logic       i_test_open,
    input  logic       i_exp_rs,
    input  logic [7:0] i_exp_byte,
    output int         o_tests_passed,
    output int         o_tests_failed,
    output int         o_errors
);

    localparam int INIT_PULSES = 14;

    int         cycle;
    int         high_cnt;
    int         last_fall;
    int         first_rise;
    int         gap_min;
    int         pulse_cnt;
    int         test_idx;
    int         test_errs;
    logic       e_prev;
    logic       busy_prev;
    logic       open_prev;
    logic       accept_prev;
    logic       init_done;
    logic       in_test;
    logic       exp_rs;
    logic [7:0] exp_byte;
    logic [3:0] exp_nybble;

    // nybbles of the 4-bit power-on init in datasheet order
    function automatic logic [3:0] init_nybble(input int idx);
        case (idx)
            0, 1, 2: init_nybble = 4'h3;
            3, 4: init_nybble = 4'h2;
            5, 7: init_nybble = 4'h8;
            9: init_nybble = 4'h1;
            11: init_nybble = 4'h6;
            13: init_nybble = 4'hc;
            default: init_nybble = 4'h0;
        endcase
    endfunction

    // clear display and return home need 3 ms before the next write and the rest 53 us
    function automatic int min_gap(input logic rs, input logic [7:0] data);
        if (!rs && (data == 8'h01 || data == 8'h02)) begin
            min_gap = US_3MS * TICKS_PER_US;
        end else begin
            min_gap = US_53US * TICKS_PER_US;
        end
    endfunction

    task automatic flag_error(input string msg);
        $display("[FAIL] %0d ns: test %0d: %s", $time, test_idx, msg);
        test_errs++;
        o_errors++;
    endtask

    task automatic close_test(input string what);
        if (test_errs == 0) begin
            $display("[PASS] test %0d %s", test_idx, what);
            o_tests_passed++;
        end else begin
            $display("[FAIL] %0d ns: test %0d %s ended with %0d errors",
                     $time, test_idx, what, test_errs);
            o_tests_failed++;
        end
    endtask

    // ****************************************
    // pin monitor sampled on the rising edge
    // ****************************************

    always @(posedge CLK_I) begin
        if (RST_I) begin
            cycle = 0;
            high_cnt = 0;
            last_fall = 0;
            first_rise = 0;
            // the last init nybble is an ordinary 53 us instruction
            gap_min = US_53US * TICKS_PER_US;
            pulse_cnt = 0;
            test_idx = 0;
            test_errs = 0;
            e_prev = 1'b0;
            busy_prev = 1'b0;
            open_prev = 1'b0;
            accept_prev = 1'b0;
            init_done = 1'b0;
            in_test = 1'b0;
            o_tests_passed = 0;
            o_tests_failed = 0;
            o_errors = 0;
        end else begin
            cycle++;
            // a strobe taken with busy low must raise busy one cycle later
            if (accept_prev && !i_busy) begin
                flag_error("busy still low in the cycle after an accepted strobe");
            end
            // the first fall of busy ends the init sequence
            if (!init_done && busy_prev && !i_busy) begin
                if (pulse_cnt != INIT_PULSES) begin
                    flag_error($sformatf("busy fell after %0d of %0d init pulses",
                                         pulse_cnt, INIT_PULSES));
                end
                close_test("init sequence");
                init_done = 1'b1;
            end
            if (i_test_open && !open_prev) begin
                test_idx++;
                test_errs = 0;
                pulse_cnt = 0;
                exp_rs = i_exp_rs;
                exp_byte = i_exp_byte;
                in_test = 1'b1;
            end
            if (!i_test_open && open_prev) begin
                // a second strobe while busy must not add a third pulse
                if (pulse_cnt != 2) begin
                    flag_error($sformatf("saw %0d E pulses, expected 2", pulse_cnt));
                end
                gap_min = min_gap(exp_rs, exp_byte);
                close_test($sformatf("rs=%0b byte=%02h", exp_rs, exp_byte));
                in_test = 1'b0;
            end
            // on a rise of E check the gap to the previous byte and the nybble spacing
            if (i_e && !e_prev && in_test) begin
                if (pulse_cnt == 0) begin
                    if (cycle - last_fall < gap_min) begin
                        flag_error($sformatf("gap of %0d cycles before the byte, expected %0d",
                                             cycle - last_fall, gap_min));
                    end
                    first_rise = cycle;
                end else if (pulse_cnt == 1) begin
                    if (cycle - first_rise < TICKS_TAS + TICKS_TCYCE) begin
                        flag_error($sformatf("nybble rises %0d cycles apart, expected %0d",
                                             cycle - first_rise, TICKS_TAS + TICKS_TCYCE));
                    end
                end
            end
            if (i_e) begin
                high_cnt++;
            end
            // the LCD latches RS and data on the fall of E
            if (!i_e && e_prev) begin
                if (high_cnt != TICKS_PWEH) begin
                    flag_error($sformatf("E high for %0d cycles, expected %0d",
                                         high_cnt, TICKS_PWEH));
                end
                high_cnt = 0;
                last_fall = cycle;
                if (!init_done) begin
                    if (pulse_cnt >= INIT_PULSES) begin
                        flag_error("extra E pulse during init");
                    end else if (i_rs || i_lcd_data != init_nybble(pulse_cnt)) begin
                        flag_error($sformatf("init nybble %0d is rs=%0b data=%h, expected %h",
                                             pulse_cnt, i_rs, i_lcd_data,
                                             init_nybble(pulse_cnt)));
                    end
                end else if (in_test) begin
                    // high nybble first, then the low one
                    exp_nybble = (pulse_cnt == 0) ? exp_byte[7:4] : exp_byte[3:0];
                    if (pulse_cnt >= 2) begin
                        flag_error("extra E pulse in the byte");
                    end else if (i_rs != exp_rs || i_lcd_data != exp_nybble) begin
                        flag_error($sformatf("nybble %0d is rs=%0b data=%h, byte was %02h",
                                             pulse_cnt, i_rs, i_lcd_data, exp_byte));
                    end
                end else begin
                    flag_error("E pulse outside any test");
                end
                pulse_cnt++;
            end
            e_prev = i_e;
            busy_prev = i_busy;
            open_prev = i_test_open;
            accept_prev = i_stb && !i_busy;
        end
    end

endmodule

// File: sim/hd44780_tb.sv
// HD44780 testbench: clock, reset, stimulus table, cycle limit, DUT and checker
`timescale 1ns/10ps

module hd44780_tb
    import hd44780_timing_pkg::*;
();

    localparam int TB_TICKS_PER_US = 1;
    localparam int NUM_ROWS = 8;
    // init is about 108,300 us and each row stays under 3,200 us, doubled for margin
    localparam int CYCLE_LIMIT =
        2 * (US_100MS + US_4P1MS + US_3MS + 1000 + 200 + 3200 * NUM_ROWS) * TB_TICKS_PER_US;

    logic       CLK_I;
    logic       RST_I;
    logic       host_stb;
    logic       host_rs;
    logic [7:0] host_byte;
    logic       lcd_busy;
    logic       lcd_rs;
    logic [3:0] lcd_data;
    logic       lcd_e;
    logic       test_open;
    logic       exp_rs;
    logic [7:0] exp_byte;
    int         tests_passed;
    int         tests_failed;
    int         errors;
    int         cycle_count = 0;
    integer     seed;

    // one row per test, {rs, second strobe while busy, byte}
    logic [9:0] rows [NUM_ROWS];

    always #20 CLK_I = ~CLK_I;

    hd44780_controller #(
        .TICKS_PER_US (TB_TICKS_PER_US)
    ) dut0 (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .i_stb      (host_stb),
        .i_rs       (host_rs),
        .i_byte     (host_byte),
        .o_busy     (lcd_busy),
        .o_rs       (lcd_rs),
        .o_lcd_data (lcd_data),
        .o_e        (lcd_e)
    );

    hd44780_checker #(
        .TICKS_PER_US (TB_TICKS_PER_US)
    ) chk0 (
        .CLK_I          (CLK_I),
        .RST_I          (RST_I),
        .i_e            (lcd_e),
        .i_rs           (lcd_rs),
        .i_lcd_data     (lcd_data),
        .i_busy         (lcd_busy),
        .i_stb          (host_stb),
        .i_test_open    (test_open),
        .i_exp_rs       (exp_rs),
        .i_exp_byte     (exp_byte),
        .o_tests_passed (tests_passed),
        .o_tests_failed (tests_failed),
        .o_errors       (errors)
    );

    task automatic fill_table();
        logic [31:0] rnd;
        seed = 32'hd5d7_0b1d;
        // clear display leads, so the 3 ms gap is measured in front of row 1
        rows[0] = {1'b0, 1'b0, 8'h01};
        rows[1] = {1'b1, 1'b0, 8'h48};
        rnd = $random(seed);
        rows[2] = {1'b1, 1'b1, rnd[7:0]};
        rows[3] = {1'b0, 1'b0, 8'h80};
        rnd = $random(seed);
        rows[4] = {1'b1, 1'b0, rnd[7:0]};
        rows[5] = {1'b0, 1'b1, 8'h02};
        rnd = $random(seed);
        rows[6] = {1'b1, 1'b0, rnd[7:0]};
        rows[7] = {1'b0, 1'b0, 8'h0c};
    endtask

    // one host byte, optionally followed by a strobe that busy must block
    task automatic send_byte(input logic rs, input logic [7:0] data, input logic dup);
        @(negedge CLK_I);
        exp_rs = rs;
        exp_byte = data;
        test_open = 1'b1;
        host_stb = 1'b1;
        host_rs = rs;
        host_byte = data;
        @(negedge CLK_I);
        host_stb = 1'b0;
        if (dup) begin
            @(negedge CLK_I);
            host_stb = 1'b1;
            host_rs = !rs;
            host_byte = ~data;
            @(negedge CLK_I);
            host_stb = 1'b0;
        end
        while (lcd_busy) begin
            @(negedge CLK_I);
        end
        test_open = 1'b0;
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial begin
        CLK_I = 1'b0;
        RST_I = 1'b1;
        host_stb = 1'b0;
        host_rs = 1'b0;
        host_byte = 8'h00;
        test_open = 1'b0;
        exp_rs = 1'b0;
        exp_byte = 8'h00;
        fill_table();
        repeat (10) @(posedge CLK_I);
        @(negedge CLK_I);
        RST_I = 1'b0;
        // busy comes up right after reset and drops once init has drained
        while (!lcd_busy) begin
            @(negedge CLK_I);
        end
        while (lcd_busy) begin
            @(negedge CLK_I);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_byte(rows[i][9], rows[i][7:0], rows[i][8]);
        end
        repeat (2) @(negedge CLK_I);
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && tests_passed == NUM_ROWS + 1) begin
            $display("TESTBENCH PASSED");
        end else begin
            if (tests_passed + tests_failed != NUM_ROWS + 1) begin
                $display("the checker closed %0d tests instead of %0d",
                         tests_passed + tests_failed, NUM_ROWS + 1);
            end
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // run limit, counted in clock cycles
    always @(posedge CLK_I) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

// File: files.f
verilog/hd44780_timing_pkg.sv
verilog/hd44780_cmd_pkg.sv
verilog/hd44780_sequencer.sv
verilog/hd44780_nybble_fifo.sv
verilog/hd44780_nybble_sender.sv
verilog/hd44780_controller.sv
sim/hd44780_checker.sv
sim/hd44780_tb.sv

// File: Bender.yml
package:
  name: hd44780_controller

sources:
  - verilog/hd44780_timing_pkg.sv
  - verilog/hd44780_cmd_pkg.sv
  - verilog/hd44780_sequencer.sv
  - verilog/hd44780_nybble_fifo.sv
  - verilog/hd44780_nybble_sender.sv
  - verilog/hd44780_controller.sv
  - target: simulation
    files:
      - sim/hd44780_checker.sv
      - sim/hd44780_tb.sv
